//--- src/prefetch_pkg.sv
/*
  Shared types and constants of the instruction prefetch buffer.
  Holds the memory port structs, the fetch FSM state encoding and the
  sequential fetch increment. Compile it ahead of every buffer module.
*/

`default_nettype none

package prefetch_pkg;

  // byte address on the instruction memory port
  typedef logic [31:0] addr_t;

  // one instruction word as returned by memory
  typedef logic [31:0] instr_t;

  // request half of the memory port, driven by the buffer
  typedef struct packed {
    logic  req;
    addr_t addr;
  } mem_req_t;

  // response half of the memory port, driven by memory
  // err is a protection fault and belongs to the request seen in the same cycle
  typedef struct packed {
    logic   gnt;
    logic   rvalid;
    instr_t rdata;
    logic   err;
  } mem_rsp_t;

  // fetch FSM states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED,
    WAIT_JUMP
  } fetch_state_e;

  // sequential fetches step by one 32-bit word
  localparam int unsigned WORD_BYTES = 4;

endpackage

`default_nettype wire

//--- src/fetch_ctrl.sv
/*
  Fetch FSM of the prefetch buffer.
  Drives the request/grant/rvalid memory port, remembers the last issued
  address and walks the word-aligned sequence from there. A branch redirects
  the request at once and turns a request still in flight into an aborted one.
  A protection fault parks the FSM until the next branch.
*/

`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic                   branch_i,
  input  prefetch_pkg::addr_t    addr_i,
  input  prefetch_pkg::mem_rsp_t mem_rsp_i,
  output prefetch_pkg::mem_req_t mem_req_o,
  input  logic                   has_room_i,
  input  logic                   out_valid_i,
  output logic                   rsp_keep_o,
  output logic                   flush_o,
  output logic                   fetch_failed_o,
  output logic                   busy_o
);

  import prefetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // last address that went out on the memory port
  addr_t        addr_q;
  addr_t        next_addr;
  logic         addr_save;

  // set once a branch has given the FSM a start address
  logic         addr_known_q;
  logic         can_fetch;

  ////////////////////
  // status
  ////////////////////

  assign busy_o  = (state_q != IDLE) || mem_req_o.req;

  // every branch throws away what the queue holds
  assign flush_o = branch_i;

  // sequential successor of the last request, aligned down to a word first
  assign next_addr = (addr_q & ~addr_t'(WORD_BYTES - 1)) + addr_t'(WORD_BYTES);

  // a branch always gets its request out, a plain fetch needs room in the queue
  assign can_fetch = req_i && (branch_i || has_room_i);

  // only the response of a live request reaches the queue
  // a response that coincides with a branch belongs to the old stream
  assign rsp_keep_o = mem_rsp_i.rvalid && (state_q == WAIT_RVALID) && !branch_i;

  ////////////////////
  // fetch FSM
  ////////////////////

  always_comb begin
    state_d        = state_q;
    mem_req_o.req  = 1'b0;
    mem_req_o.addr = branch_i ? addr_i : next_addr;
    addr_save      = 1'b0;
    fetch_failed_o = 1'b0;

    unique case (state_q)
      // nothing outstanding
      IDLE: begin
        // before the first branch there is no address to continue from
        if (req_i && (branch_i || (has_room_i && addr_known_q))) begin
          mem_req_o.req = 1'b1;
          addr_save     = 1'b1;
          state_d       = mem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
        end
      end

      // request is up and waits for its grant
      WAIT_GNT: begin
        mem_req_o.req = 1'b1;
        if (branch_i) begin
          // nothing was granted yet, so the request simply moves to the target
          addr_save = 1'b1;
        end else begin
          mem_req_o.addr = addr_q;
        end
        if (mem_rsp_i.gnt) begin
          state_d = WAIT_RVALID;
        end
      end

      // one request is outstanding
      WAIT_RVALID: begin
        if (can_fetch) begin
          if (mem_rsp_i.rvalid) begin
            // the port frees up this cycle, so the next request overlaps
            mem_req_o.req = 1'b1;
            addr_save     = 1'b1;
            state_d       = mem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
          end else if (branch_i) begin
            // the outstanding response is now stale
            // the target is kept and requested once the stale rvalid is in
            addr_save = 1'b1;
            state_d   = WAIT_ABORTED;
          end
        end else if (mem_rsp_i.rvalid) begin
          // the queue is full or the core stopped asking
          state_d = IDLE;
        end
      end

      // an aborted response is still on its way
      WAIT_ABORTED: begin
        if (branch_i) begin
          addr_save = 1'b1;
        end else begin
          mem_req_o.addr = addr_q;
        end
        // the core keeps req_i high after a branch, so the target goes out
        // in the cycle the stale response is dropped
        if (mem_rsp_i.rvalid) begin
          mem_req_o.req = 1'b1;
          state_d       = mem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
        end
      end

      // a protection fault stopped the stream
      WAIT_JUMP: begin
        // the fault shows only once all good words have left the queue
        fetch_failed_o = !out_valid_i;
        if (branch_i) begin
          fetch_failed_o = 1'b0;
          mem_req_o.req  = 1'b1;
          addr_save      = 1'b1;
          state_d        = mem_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // memory refuses a faulting request and sends no response for it
    if (mem_req_o.req && mem_rsp_i.err) begin
      state_d = WAIT_JUMP;
    end
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      addr_q       <= '0;
      addr_known_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (addr_save) begin
        addr_q       <= mem_req_o.addr;
        addr_known_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/instr_queue.sv
/*
  Instruction queue of the prefetch buffer.
  A circular FIFO of FIFO_DEPTH words (at least 2) with a usage count.
  While it is empty and the consumer is ready, a kept memory response
  passes straight through to the output in the same cycle.
*/

`timescale 1ns/1ps
`default_nettype none

module instr_queue #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush_i,
  input  logic                 rsp_keep_i,
  input  prefetch_pkg::instr_t rdata_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output prefetch_pkg::instr_t rdata_o,
  output logic                 has_room_o
);

  import prefetch_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  instr_t           mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] usage_q;

  logic             empty;
  logic             push;
  logic             pop;

  ////////////////////
  // output side
  ////////////////////

  assign empty = (usage_q == '0);

  // queued words go first, the bypass only serves an empty queue
  assign valid_o = !empty || rsp_keep_i;
  assign rdata_o = empty ? rdata_i : mem_q[rd_ptr_q];

  assign pop  = !empty && ready_i;

  // a kept word is stored unless it leaves through the bypass right now
  assign push = rsp_keep_i && (!empty || !ready_i);

  // one slot stays free for the response of the request in flight
  assign has_room_o = (usage_q < CNT_W'(FIFO_DEPTH - 1));

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= rdata_i;
    end
  end

  // pointers wrap at FIFO_DEPTH, which need not be a power of two
  // flush wins over a push or pop of the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        usage_q <= usage_q + 1'b1;
      end else if (pop && !push) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/prefetch_buffer.sv
/*
  Top level of the instruction prefetch buffer.
  Joins the fetch FSM and the instruction queue. The core side is a
  valid/ready port; the memory side is a request/grant/rvalid port.
  FIFO_DEPTH sets the queue size and is passed down to the queue.
*/

`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic                   branch_i,
  input  prefetch_pkg::addr_t    addr_i,
  input  logic                   ready_i,
  output logic                   valid_o,
  output prefetch_pkg::instr_t   rdata_o,
  output prefetch_pkg::mem_req_t mem_req_o,
  input  prefetch_pkg::mem_rsp_t mem_rsp_i,
  output logic                   fetch_failed_o,
  output logic                   busy_o
);

  // controller to queue
  logic rsp_keep;
  logic flush;

  // queue to controller
  logic has_room;

  fetch_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .addr_i         (addr_i),
    .mem_rsp_i      (mem_rsp_i),
    .mem_req_o      (mem_req_o),
    .has_room_i     (has_room),
    .out_valid_i    (valid_o),
    .rsp_keep_o     (rsp_keep),
    .flush_o        (flush),
    .fetch_failed_o (fetch_failed_o),
    .busy_o         (busy_o)
  );

  instr_queue #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush),
    .rsp_keep_i (rsp_keep),
    .rdata_i    (mem_rsp_i.rdata),
    .ready_i    (ready_i),
    .valid_o    (valid_o),
    .rdata_o    (rdata_o),
    .has_room_o (has_room)
  );

endmodule

`default_nettype wire

//--- tb/instr_mem_model.sv
/*
  Instruction memory responder for the prefetch buffer testbench.
  Grants a request after 0 to 3 cycles and returns rvalid 1 to 4 cycles
  after the grant, both drawn from the random word on rnd_i. The read data
  comes from the testbench for the address on rsp_addr_o. Requests into
  [PROT_LO, PROT_HI] get err instead of a grant.
*/

`timescale 1ns/1ps
`default_nettype none

module instr_mem_model #(
  parameter prefetch_pkg::addr_t PROT_LO = '0,
  parameter prefetch_pkg::addr_t PROT_HI = '0
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  prefetch_pkg::mem_req_t mem_req_i,
  output prefetch_pkg::mem_rsp_t mem_rsp_o,
  input  logic [31:0]            rnd_i,
  input  prefetch_pkg::instr_t   rdata_i,
  output prefetch_pkg::addr_t    rsp_addr_o
);

  import prefetch_pkg::*;

  logic [1:0] gnt_wait_q;
  logic [1:0] rsp_wait_q;
  logic       pending_q;
  addr_t      rsp_addr_q;
  logic       prot_hit;
  logic       gnt;
  logic       rvalid;

  // a faulting request is refused outright and never granted
  assign prot_hit = mem_req_i.req && (mem_req_i.addr >= PROT_LO) && (mem_req_i.addr <= PROT_HI);
  assign gnt      = mem_req_i.req && !prot_hit && (gnt_wait_q == 2'd0);
  assign rvalid   = pending_q && (rsp_wait_q == 2'd0);

  assign mem_rsp_o.gnt    = gnt;
  assign mem_rsp_o.rvalid = rvalid;
  assign mem_rsp_o.rdata  = rvalid ? rdata_i : '0;
  assign mem_rsp_o.err    = prot_hit;
  assign rsp_addr_o       = rsp_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_wait_q <= '0;
      rsp_wait_q <= '0;
      pending_q  <= 1'b0;
      rsp_addr_q <= '0;
    end else begin
      // count down while a request waits, draw a fresh delay otherwise
      if (mem_req_i.req && !gnt) begin
        if (gnt_wait_q != 2'd0) begin
          gnt_wait_q <= gnt_wait_q - 2'd1;
        end
      end else begin
        gnt_wait_q <= rnd_i[19:18];
      end
      // a grant in the rvalid cycle starts the next response at once
      if (gnt) begin
        pending_q  <= 1'b1;
        rsp_addr_q <= mem_req_i.addr;
        rsp_wait_q <= rnd_i[23:22];
      end else if (rvalid) begin
        pending_q <= 1'b0;
      end else if (pending_q) begin
        rsp_wait_q <= rsp_wait_q - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/prefetch_assert.sv
/*
  Memory port and output assertions for the prefetch buffer.
  Bound into every prefetch_buffer instance.
*/

`timescale 1ns/1ps
`default_nettype none

module prefetch_assert (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   branch_i,
  input prefetch_pkg::mem_req_t mem_req_i,
  input prefetch_pkg::mem_rsp_t mem_rsp_i,
  input logic                   valid_i,
  input logic                   fetch_failed_i
);

  // one request may be in flight, a new grant replaces the finished one
  logic outstanding_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= 1'b0;
    end else if (mem_req_i.req && mem_rsp_i.gnt) begin
      outstanding_q <= 1'b1;
    end else if (mem_rsp_i.rvalid) begin
      outstanding_q <= 1'b0;
    end
  end

  // only a branch may move the address of a request still waiting for its grant
  assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i.req && !mem_rsp_i.gnt && !mem_rsp_i.err
      |=> mem_req_i.req && (branch_i || $stable(mem_req_i.addr)))
    else $error("memory request dropped or moved before its grant");

  assert property (@(posedge clk) disable iff (!rst_n)
    mem_rsp_i.rvalid |-> outstanding_q)
    else $error("rvalid without an outstanding request");

  assert property (@(posedge clk) disable iff (!rst_n)
    !(valid_i && fetch_failed_i))
    else $error("valid_o and fetch_failed_o high together");

endmodule

bind prefetch_buffer prefetch_assert u_assert (
  .clk            (clk),
  .rst_n          (rst_n),
  .branch_i       (branch_i),
  .mem_req_i      (mem_req_o),
  .mem_rsp_i      (mem_rsp_i),
  .valid_i        (valid_o),
  .fetch_failed_i (fetch_failed_o)
);

`default_nettype wire

//--- tb/tb_prefetch_buffer.sv
/*
  Testbench of the instruction prefetch buffer.
  Drives the core port on the falling edge, answers the memory port with
  instr_mem_model and compares every transfer with expected_instr of the
  address the stream should have reached. Runs reset, sequential stream,
  back-pressure, branch redirect and protection fault cases in turn.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_prefetch_buffer;

  import prefetch_pkg::*;

  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned TIMEOUT    = 2000;
  localparam logic [31:0] LCG_SEED   = 32'h93cf3f74;
  localparam addr_t       PROT_LO    = 32'h0000_3020;
  localparam addr_t       PROT_HI    = 32'h0000_30ff;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req;
  logic        branch;
  addr_t       addr;
  logic        ready;
  logic        valid;
  instr_t      rdata;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  logic        fetch_failed;
  logic        busy;
  instr_t      mem_rdata;
  addr_t       rsp_addr;
  logic [31:0] rnd_q = LCG_SEED;
  logic        random_ready;

  // scoreboard state
  addr_t       exp_addr;
  int unsigned xfer_cnt;
  int          live_cnt;
  int          live_next;
  int unsigned sb_errors;
  int unsigned seq_errors;

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // reference word at a byte address, the address mixed with a hash of its word index
  function automatic instr_t expected_instr(input addr_t a);
    return a ^ lcg_next({2'b00, a[31:2]});
  endfunction

  prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req),
    .branch_i       (branch),
    .addr_i         (addr),
    .ready_i        (ready),
    .valid_o        (valid),
    .rdata_o        (rdata),
    .mem_req_o      (mem_req),
    .mem_rsp_i      (mem_rsp),
    .fetch_failed_o (fetch_failed),
    .busy_o         (busy)
  );

  instr_mem_model #(
    .PROT_LO (PROT_LO),
    .PROT_HI (PROT_HI)
  ) u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_req_i  (mem_req),
    .mem_rsp_o  (mem_rsp),
    .rnd_i      (rnd_q),
    .rdata_i    (mem_rdata),
    .rsp_addr_o (rsp_addr)
  );

  assign mem_rdata = expected_instr(rsp_addr);

  // one random word per cycle feeds the memory delays and the ready pattern
  always @(negedge clk) begin
    rnd_q <= lcg_next(rnd_q);
  end

  ////////////////////
  // scoreboard
  ////////////////////

  // live_cnt counts granted words of the current stream not yet consumed
  // more than FIFO_DEPTH of them means a request went out over a full queue
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_addr  <= '0;
      xfer_cnt  <= 0;
      live_cnt  <= 0;
      sb_errors <= 0;
    end else if (branch) begin
      exp_addr <= addr;
      live_cnt <= mem_rsp.gnt ? 1 : 0;
    end else begin
      live_next = live_cnt + (mem_rsp.gnt ? 1 : 0) - ((valid && ready) ? 1 : 0);
      live_cnt <= live_next;
      if (live_next > int'(FIFO_DEPTH)) begin
        $display("memory request granted at %0t while the queue was full", $time);
        sb_errors <= sb_errors + 1;
      end
      if (valid && ready) begin
        if (rdata !== expected_instr(exp_addr)) begin
          $display("ERR %0t rdata_o: got %h, expected %h", $time, rdata,
                   expected_instr(exp_addr));
          sb_errors <= sb_errors + 1;
        end
        exp_addr <= exp_addr + 32'd4;
        xfer_cnt <= xfer_cnt + 1;
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic report_and_finish();
    $display("errors: %0d in the scoreboard, %0d in the sequence checks",
             sb_errors, seq_errors);
    if (sb_errors == 0 && seq_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got %b, expected %b", $time, name, got, exp);
      seq_errors++;
    end
  endtask

  // one falling edge, branch drops and ready takes its next value
  task automatic drive_cycle();
    @(negedge clk);
    branch = 1'b0;
    ready  = random_ready ? rnd_q[29] : 1'b1;
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) drive_cycle();
  endtask

  // ready stays low in the branch cycle so no old word is taken there
  task automatic do_branch(input addr_t target);
    @(negedge clk);
    req    = 1'b1;
    branch = 1'b1;
    addr   = target;
    ready  = 1'b0;
    drive_cycle();
  endtask

  task automatic wait_xfers(input int unsigned n);
    int unsigned target;
    int unsigned cycles;
    target = xfer_cnt + n;
    cycles = 0;
    while (xfer_cnt < target) begin
      if (cycles == TIMEOUT) begin
        $display("timeout: only %0d of %0d transfers arrived", n - (target - xfer_cnt), n);
        seq_errors++;
        report_and_finish();
      end else begin
        drive_cycle();
        cycles++;
      end
    end
  endtask

  task automatic wait_failed();
    int unsigned cycles;
    cycles = 0;
    @(posedge clk);
    while (fetch_failed !== 1'b1) begin
      if (cycles == TIMEOUT) begin
        $display("timeout: fetch_failed_o never rose after the protection fault");
        seq_errors++;
        report_and_finish();
      end else begin
        drive_cycle();
        @(posedge clk);
        cycles++;
      end
    end
  endtask

  initial begin
    int unsigned k;
    int unsigned start;
    seq_errors   = 0;
    rst_n        = 1'b0;
    req          = 1'b0;
    branch       = 1'b0;
    addr         = '0;
    ready        = 1'b0;
    random_ready = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // everything stays quiet until the first branch
    repeat (2) begin
      @(posedge clk);
      expect_bit("mem_req_o.req", mem_req.req, 1'b0);
      expect_bit("valid_o", valid, 1'b0);
      expect_bit("fetch_failed_o", fetch_failed, 1'b0);
      expect_bit("busy_o", busy, 1'b0);
    end

    // sequential stream, then the same stream under back-pressure
    do_branch(32'h0000_1000);
    wait_xfers(32);
    random_ready = 1'b1;
    wait_xfers(48);

    // redirects land in every FSM state, a stale word would break the compare
    for (k = 0; k < 12; k++) begin
      idle_cycles(1 + rnd_q[27:25]);
      do_branch(32'h0001_0000 + k * 32'h100);
    end
    wait_xfers(20);

    // stream runs into the protected range at PROT_LO
    random_ready = 1'b0;
    do_branch(32'h0000_3000);
    start = xfer_cnt;
    wait_xfers(8);
    wait_failed();
    if (xfer_cnt != start + 8) begin
      $display("%0d words delivered before the fault instead of 8", xfer_cnt - start);
      seq_errors++;
    end
    // the parked FSM still counts as busy while it waits for a branch
    repeat (8) begin
      drive_cycle();
      @(posedge clk);
      expect_bit("valid_o", valid, 1'b0);
      expect_bit("fetch_failed_o", fetch_failed, 1'b1);
      expect_bit("busy_o", busy, 1'b1);
    end

    // a branch to a safe address restarts the stream
    do_branch(32'h0000_4000);
    wait_xfers(16);
    report_and_finish();
  end

endmodule

`default_nettype wire

//--- prefetch_buffer.f
src/prefetch_pkg.sv
src/fetch_ctrl.sv
src/instr_queue.sv
src/prefetch_buffer.sv
tb/instr_mem_model.sv
tb/prefetch_assert.sv
tb/tb_prefetch_buffer.sv

//--- Makefile
# Verilator build and run of the prefetch buffer testbench
VERILATOR ?= verilator
TOP       ?= tb_prefetch_buffer
FILELIST  ?= prefetch_buffer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, a run that never reaches its report also fails
run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); then \
	  echo "run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
